/* design/emu_glue_pkg.sv */
// Shared types and constants for the MSX glue logic, imported by every glue module
`default_nettype none

package emu_glue_pkg;

   // ====================
   // Vector types
   // ====================

   // Host status word from the OSD menu
   typedef logic [63:0] status_t;

   // HDMI output resolution, one axis
   typedef logic [11:0] hdmi_dim_t;

   // Vertical crop in scanlines
   typedef logic [9:0] crop_size_t;

   // One aspect ratio component
   typedef logic [11:0] aspect_t;

   typedef logic [1:0]  scanline_t;
   typedef logic [1:0]  ar_sel_t;
   typedef logic [15:0] ioctl_index_t;
   typedef logic [31:0] img_size_t;

   // Byte address into the DDR3 buffer
   typedef logic [27:0] ddr3_addr_t;

   typedef logic [15:0] sample_t;

   // Where the cassette input bit comes from
   typedef enum logic {
      TAPE_SRC_FILE = 1'b0,
      TAPE_SRC_ADC  = 1'b1
   } tape_src_e;

   // ====================
   // Image and download slots
   // ====================
   localparam int VDNUM    = 6;
   localparam int VSD_SLOT = 4;

   // Only the low six index bits select the file type
   localparam logic [5:0] CAS_INDEX = 6'd5;

   // ====================
   // Status word layout
   // ====================
   localparam int ST_RESET    = 0;
   localparam int ST_AR_LSB   = 1;
   localparam int ST_FX_LSB   = 3;
   localparam int FX_W        = 3;
   localparam int ST_TAPE_SRC = 8;
   localparam int ST_REWIND   = 9;
   localparam int ST_DETACH   = 10;
   localparam int ST_VCROP    = 40;

   // Aspect values handed to the scaler
   localparam aspect_t ARX_NORMAL = 12'd400;
   localparam aspect_t ARX_WIDE   = 12'd340;
   localparam aspect_t ARY_NORMAL = 12'd300;

   // Crop line counts
   localparam crop_size_t CROP_240 = 10'd240;
   localparam crop_size_t CROP_256 = 10'd256;
   localparam crop_size_t CROP_200 = 10'd200;
   localparam crop_size_t CROP_216 = 10'd216;

   // 4:3 modes at or above this width still get a crop
   localparam hdmi_dim_t WIDE_MIN_WIDTH = 12'd1440;

   // About 47 ms at 21.48 MHz
   localparam int ACT_TIMEOUT_DEFAULT = 1_000_000;

endpackage

`default_nettype wire

/* design/emu_glue_top.sv */
// Top level of the MSX glue logic, connects the decode, video, SD and tape blocks to the pins
`timescale 1ns/10ps
`default_nettype none

module emu_glue_top #(
   parameter int act_timeout = emu_glue_pkg::ACT_TIMEOUT_DEFAULT
) (
   input  logic                                 clk21m,
   input  logic                                 rst,
   // Host and loader
   input  logic                                 reset_rq,
   input  emu_glue_pkg::status_t                status,
   input  logic                                 forced_scandoubler,
   input  logic                                 ioctl_download,
   input  emu_glue_pkg::ioctl_index_t           ioctl_index,
   input  logic [emu_glue_pkg::VDNUM-1:0]       img_mounted,
   input  emu_glue_pkg::img_size_t              img_size,
   // Video
   input  emu_glue_pkg::hdmi_dim_t              hdmi_width,
   input  emu_glue_pkg::hdmi_dim_t              hdmi_height,
   output emu_glue_pkg::scanline_t              scanlines,
   output logic                                 hq2x,
   output logic                                 scandoubler,
   output emu_glue_pkg::crop_size_t             crop_size,
   output emu_glue_pkg::aspect_t                arx,
   output emu_glue_pkg::aspect_t                ary,
   // SD card
   input  logic                                 spi_clk,
   input  logic                                 spi_mosi,
   input  logic                                 card_miso,
   input  logic                                 vsd_miso,
   output logic                                 spi_miso,
   output logic                                 sd_sck,
   output logic                                 sd_mosi,
   output logic                                 sd_cs,
   output logic                                 led_user,
   output logic                                 led_disk_act,
   // Cassette
   input  logic                                 motor,
   input  logic                                 cas_file_bit,
   input  logic                                 tape_adc,
   input  logic                                 tape_adc_act,
   output logic                                 play,
   output logic                                 rewind,
   output logic                                 cas_audio_in,
   // DDR3 read port
   input  logic                                 ddr3_request_download,
   input  logic                                 ddr3_rd_download,
   input  logic                                 ddr3_rd_cas,
   input  emu_glue_pkg::ddr3_addr_t             ddr3_addr_download,
   input  emu_glue_pkg::ddr3_addr_t             ddr3_addr_cas,
   output logic                                 ddr3_rd,
   output emu_glue_pkg::ddr3_addr_t             ddr3_addr,
   // Audio
   input  emu_glue_pkg::sample_t                audio_in,
   output emu_glue_pkg::sample_t                audio_l,
   output emu_glue_pkg::sample_t                audio_r
);
   import emu_glue_pkg::*;

   logic      core_reset;
   logic      vcrop_en;
   logic      rewind_req;
   ar_sel_t   ar;
   tape_src_e tape_src;

   // ====================
   // Control decode
   // ====================
   status_decode u_status_decode (
      .rst                (rst),
      .reset_rq           (reset_rq),
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .core_reset         (core_reset),
      .scanlines          (scanlines),
      .hq2x               (hq2x),
      .scandoubler        (scandoubler),
      .vcrop_en           (vcrop_en),
      .rewind_req         (rewind_req),
      .ar                 (ar),
      .tape_src           (tape_src)
   );

   video_crop_select u_video_crop_select (
      .clk21m      (clk21m),
      .rst         (rst),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .scandoubler (scandoubler),
      .vcrop_en    (vcrop_en),
      .ar          (ar),
      .crop_size   (crop_size),
      .arx         (arx),
      .ary         (ary)
   );

   // ====================
   // SD and tape
   // ====================
   sd_route #(
      .act_timeout (act_timeout)
   ) u_sd_route (
      .clk21m          (clk21m),
      .rst             (rst),
      .img_mounted_vsd (img_mounted[VSD_SLOT]),
      .img_size        (img_size),
      .spi_clk         (spi_clk),
      .spi_mosi        (spi_mosi),
      .card_miso       (card_miso),
      .vsd_miso        (vsd_miso),
      .spi_miso        (spi_miso),
      .sd_sck          (sd_sck),
      .sd_mosi         (sd_mosi),
      .sd_cs           (sd_cs),
      .led_user        (led_user),
      .led_disk_act    (led_disk_act)
   );

   tape_ddr3_path u_tape_ddr3_path (
      .clk21m                (clk21m),
      .rst                   (rst),
      .core_reset            (core_reset),
      .rewind_req            (rewind_req),
      .tape_src              (tape_src),
      .ioctl_download        (ioctl_download),
      .ioctl_index           (ioctl_index),
      .motor                 (motor),
      .cas_file_bit          (cas_file_bit),
      .tape_adc              (tape_adc),
      .tape_adc_act          (tape_adc_act),
      .ddr3_request_download (ddr3_request_download),
      .ddr3_rd_download      (ddr3_rd_download),
      .ddr3_rd_cas           (ddr3_rd_cas),
      .ddr3_addr_download    (ddr3_addr_download),
      .ddr3_addr_cas         (ddr3_addr_cas),
      .play                  (play),
      .rewind                (rewind),
      .cas_audio_in          (cas_audio_in),
      .ddr3_rd               (ddr3_rd),
      .ddr3_addr             (ddr3_addr)
   );

   // Mono core output on both channels
   assign audio_l = audio_in;
   assign audio_r = audio_in;

endmodule

`default_nettype wire

/* design/sd_route.sv */
// Routes SPI to the physical SD card or the virtual image and times card activity for the LEDs
`timescale 1ns/10ps
`default_nettype none

module sd_route #(
   parameter int act_timeout = emu_glue_pkg::ACT_TIMEOUT_DEFAULT
) (
   input  logic                     clk21m,
   input  logic                     rst,
   input  logic                     img_mounted_vsd,
   input  emu_glue_pkg::img_size_t  img_size,
   input  logic                     spi_clk,
   input  logic                     spi_mosi,
   input  logic                     card_miso,
   input  logic                     vsd_miso,
   output logic                     spi_miso,
   output logic                     sd_sck,
   output logic                     sd_mosi,
   output logic                     sd_cs,
   output logic                     led_user,
   output logic                     led_disk_act
);
   localparam int CNT_W = $clog2(act_timeout + 1);

   logic             vsd_sel;
   logic             mosi_q;
   logic             miso_q;
   logic             sd_act;
   logic [CNT_W-1:0] quiet_cnt;

   // ====================
   // Card selection
   // ====================

   // A mount on the SD slot with a real image switches to virtual
   always_ff @(posedge clk21m) begin
      if (rst) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_vsd) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical card is deselected and kept quiet while virtual
   assign sd_cs    = vsd_sel;
   assign sd_sck   = spi_clk & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;
   assign spi_miso = vsd_sel ? vsd_miso : card_miso;

   // ====================
   // Activity timer
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         mosi_q    <= 1'b0;
         miso_q    <= 1'b0;
         sd_act    <= 1'b0;
         quiet_cnt <= CNT_W'(act_timeout);
      end else begin
         mosi_q <= spi_mosi;
         miso_q <= spi_miso;
         sd_act <= 1'b0;
         if (quiet_cnt < act_timeout) begin
            quiet_cnt <= quiet_cnt + 1'b1;
            sd_act    <= 1'b1;
         end
         // Any data line edge restarts the quiet period
         if ((mosi_q ^ spi_mosi) || (miso_q ^ spi_miso)) begin
            quiet_cnt <= '0;
         end
      end
   end

   assign led_user     = vsd_sel & sd_act;
   assign led_disk_act = ~vsd_sel & sd_act;

endmodule

`default_nettype wire

/* design/status_decode.sv */
// Decodes the host status word and reset sources into control levels for the rest of the glue
`timescale 1ns/10ps
`default_nettype none

module status_decode (
   input  logic                     rst,
   input  logic                     reset_rq,
   input  emu_glue_pkg::status_t    status,
   input  logic                     forced_scandoubler,
   output logic                     core_reset,
   output emu_glue_pkg::scanline_t  scanlines,
   output logic                     hq2x,
   output logic                     scandoubler,
   output logic                     vcrop_en,
   output logic                     rewind_req,
   output emu_glue_pkg::ar_sel_t    ar,
   output emu_glue_pkg::tape_src_e  tape_src
);
   import emu_glue_pkg::*;

   // Scandoubler effect selection from the video menu
   logic [FX_W-1:0] fx;

   assign fx = status[ST_FX_LSB +: FX_W];

   // ====================
   // Reset
   // ====================

   // Board reset, menu reset, detach and loader request all restart the core
   assign core_reset = rst
                     | status[ST_RESET]
                     | status[ST_DETACH]
                     | reset_rq;

   // ====================
   // Video
   // ====================

   // CRT levels start at effect 3
   assign scanlines = (fx > 3'd2) ? scanline_t'(fx - 3'd2) : '0;

   // Effects 1 and 2 are the two HQ2x variants
   assign hq2x = (fx == 3'd1) || (fx == 3'd2);

   assign scandoubler = (fx != '0) || forced_scandoubler;

   assign vcrop_en = status[ST_VCROP];
   assign ar       = status[ST_AR_LSB +: $bits(ar_sel_t)];

   // ====================
   // Tape
   // ====================
   assign rewind_req = status[ST_REWIND];
   assign tape_src   = status[ST_TAPE_SRC] ? TAPE_SRC_ADC : TAPE_SRC_FILE;

endmodule

`default_nettype wire

/* design/tape_ddr3_path.sv */
// Cassette load, play and rewind control, tape audio selection and DDR3 read port sharing
`timescale 1ns/10ps
`default_nettype none

module tape_ddr3_path (
   input  logic                        clk21m,
   input  logic                        rst,
   input  logic                        core_reset,
   input  logic                        rewind_req,
   input  emu_glue_pkg::tape_src_e     tape_src,
   input  logic                        ioctl_download,
   input  emu_glue_pkg::ioctl_index_t  ioctl_index,
   input  logic                        motor,
   input  logic                        cas_file_bit,
   input  logic                        tape_adc,
   input  logic                        tape_adc_act,
   input  logic                        ddr3_request_download,
   input  logic                        ddr3_rd_download,
   input  logic                        ddr3_rd_cas,
   input  emu_glue_pkg::ddr3_addr_t    ddr3_addr_download,
   input  emu_glue_pkg::ddr3_addr_t    ddr3_addr_cas,
   output logic                        play,
   output logic                        rewind,
   output logic                        cas_audio_in,
   output logic                        ddr3_rd,
   output emu_glue_pkg::ddr3_addr_t    ddr3_addr
);
   import emu_glue_pkg::*;

   logic cas_dl;
   logic cas_dl_q;
   logic cas_load;

   // ====================
   // Cassette load
   // ====================
   assign cas_dl = ioctl_download && (ioctl_index[5:0] == CAS_INDEX);

   // Arms once the first cassette download finishes
   always_ff @(posedge clk21m) begin
      if (rst) begin
         cas_dl_q <= 1'b0;
         cas_load <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         if (cas_dl_q && !cas_dl) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Motor is active low from the PPI
   assign play   = ~motor & cas_load;
   assign rewind = rewind_req | cas_dl | core_reset;

   // ADC bit only counts while the receiver sees a signal
   assign cas_audio_in = (tape_src == TAPE_SRC_FILE) ? cas_file_bit
                                                     : (tape_adc_act & tape_adc);

   // ====================
   // DDR3 read port
   // ====================

   // Loader wins while it holds the request, the tape reader waits
   assign ddr3_addr = ddr3_request_download ? ddr3_addr_download : ddr3_addr_cas;
   assign ddr3_rd   = ddr3_request_download ? ddr3_rd_download   : ddr3_rd_cas;

endmodule

`default_nettype wire

/* design/video_crop_select.sv */
// Picks the vertical crop and wide flag from the HDMI mode and forms the aspect outputs
`timescale 1ns/10ps
`default_nettype none

module video_crop_select (
   input  logic                      clk21m,
   input  logic                      rst,
   input  emu_glue_pkg::hdmi_dim_t   hdmi_width,
   input  emu_glue_pkg::hdmi_dim_t   hdmi_height,
   input  logic                      scandoubler,
   input  logic                      vcrop_en,
   input  emu_glue_pkg::ar_sel_t     ar,
   output emu_glue_pkg::crop_size_t  crop_size,
   output emu_glue_pkg::aspect_t     arx,
   output emu_glue_pkg::aspect_t     ary
);
   import emu_glue_pkg::*;

   // Height times 1.5, one bit wider so large modes do not wrap
   logic [12:0] height_x15;
   logic        is_widescreen;
   logic        is_big_43;

   crop_size_t  crop_nxt;
   logic        wide_nxt;
   crop_size_t  crop_q;
   logic        wide_q;

   assign height_x15    = {1'b0, hdmi_height} + {2'b00, hdmi_height[11:1]};
   assign is_widescreen = ({1'b0, hdmi_width} >= height_x15) && !scandoubler;
   assign is_big_43     = (hdmi_width >= WIDE_MIN_WIDTH) && !scandoubler;

   // ====================
   // Crop table
   // ====================
   always_comb begin
      crop_nxt = '0;
      wide_nxt = 1'b0;
      if (is_widescreen) begin
         case (hdmi_height)
            12'd480:  crop_nxt = CROP_240;
            12'd600: begin
               crop_nxt = CROP_200;
               wide_nxt = vcrop_en;
            end
            12'd720:  crop_nxt = CROP_240;
            // NTSC shows only 250 lines, so 256 leaves a small border
            12'd768:  crop_nxt = CROP_256;
            12'd800: begin
               crop_nxt = CROP_200;
               wide_nxt = vcrop_en;
            end
            12'd1080: crop_nxt = CROP_216;
            12'd1200: crop_nxt = CROP_240;
            default:  crop_nxt = '0;
         endcase
      end else if (is_big_43) begin
         // 1920x1440 and 2048x1536 fail the 1.5 ratio test
         case (hdmi_height)
            12'd1440: crop_nxt = CROP_240;
            12'd1536: crop_nxt = CROP_256;
            default:  crop_nxt = '0;
         endcase
      end
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         crop_q <= '0;
         wide_q <= 1'b0;
      end else begin
         crop_q <= crop_nxt;
         wide_q <= wide_nxt;
      end
   end

   // ====================
   // Outputs to the scaler
   // ====================
   assign crop_size = vcrop_en ? crop_q : '0;

   // ar of zero means original aspect, otherwise custom ratio ar-1
   always_comb begin
      if (ar == '0) begin
         arx = wide_q ? ARX_WIDE : ARX_NORMAL;
         ary = ARY_NORMAL;
      end else begin
         arx = {10'd0, ar} - 12'd1;
         ary = '0;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_emu_glue \
   -o sim_emu_glue || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_emu_glue)
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1

/* sources.f */
design/emu_glue_pkg.sv
design/status_decode.sv
design/video_crop_select.sv
design/sd_route.sv
design/tape_ddr3_path.sv
design/emu_glue_top.sv
verif/tb_emu_glue.sv

/* verif/tb_emu_glue.sv */
// Self-checking testbench for emu_glue_top; run it as the simulation top with the file list
`timescale 1ns/10ps
`default_nettype none

module tb_emu_glue;
   import emu_glue_pkg::*;

   localparam int ACT_TO = 64;
   // Cycle budget per test, with slack for the watchdog
   localparam int CYC_RESET  = 10;
   localparam int CYC_STATUS = 40 * 2;
   localparam int CYC_CROP   = 40 * 5;
   localparam int CYC_SD     = 40;
   localparam int CYC_ACT    = 2 * (ACT_TO + 20 + 110);
   localparam int CYC_CAS    = 40;
   localparam int CYC_DDR3   = 40 * 2;
   localparam int TIMEOUT_NS = (CYC_RESET + CYC_STATUS + CYC_CROP + CYC_SD + CYC_ACT
                               + CYC_CAS + CYC_DDR3 + 400) * 100;

   logic clk21m, rst, reset_rq, forced_scandoubler, ioctl_download;
   status_t status;
   ioctl_index_t ioctl_index;
   logic [VDNUM-1:0] img_mounted;
   img_size_t img_size;
   hdmi_dim_t hdmi_width, hdmi_height;
   scanline_t scanlines;
   logic hq2x, scandoubler;
   crop_size_t crop_size;
   aspect_t arx, ary;
   logic spi_clk, spi_mosi, card_miso, vsd_miso, spi_miso, sd_sck, sd_mosi, sd_cs;
   logic led_user, led_disk_act;
   logic motor, cas_file_bit, tape_adc, tape_adc_act, play, rewind, cas_audio_in;
   logic ddr3_request_download, ddr3_rd_download, ddr3_rd_cas, ddr3_rd;
   ddr3_addr_t ddr3_addr_download, ddr3_addr_cas, ddr3_addr;
   sample_t audio_in, audio_l, audio_r;

   logic [31:0] rng_state = 32'h7bae;
   int checks = 0;
   int errors = 0;
   int test_errors = 0;
   int test_checks = 0;

   emu_glue_top #(.act_timeout(ACT_TO)) DUT (.*);

   initial begin
      clk21m = 1'b0;
      forever #50 clk21m = ~clk21m;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // ====================
   // Reference model
   // ====================

   // Returns {hq2x, scandoubler, scanlines}
   function automatic logic [3:0] fx_ref(logic [2:0] fx, logic forced);
      logic [1:0] sl;
      sl = (fx > 2) ? 2'(fx - 3'd2) : 2'd0;
      return {(fx == 1 || fx == 2), (fx != 0 || forced), sl};
   endfunction

   // Returns {wide, crop}
   function automatic logic [10:0] crop_ref(int w, int h, logic sd, logic vc);
      int c;
      logic wd;
      c = 0;
      wd = 1'b0;
      if (!sd && 2 * w >= 3 * h) begin
         case (h)
            480, 720, 1200: c = 240;
            600, 800: begin
               c = 200;
               wd = vc;
            end
            768:  c = 256;
            1080: c = 216;
            default: c = 0;
         endcase
      end else if (!sd && w >= 1440) begin
         if (h == 1440) c = 240;
         else if (h == 1536) c = 256;
      end
      return {wd, c[9:0]};
   endfunction

   function automatic logic [23:0] aspect_ref(logic [1:0] a, logic wd);
      if (a == 0)
         return {(wd ? 12'd340 : 12'd400), 12'd300};
      return {12'(a) - 12'd1, 12'd0};
   endfunction

   // ====================
   // Checking and reporting
   // ====================
   task automatic check(logic [63:0] got, logic [63:0] exp, string what);
      checks++;
      test_checks++;
      assert (got === exp) else begin
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic end_test(string name);
      $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // ====================
   // Tests
   // ====================
   task automatic status_test();
      logic [3:0] e;
      repeat (40) begin
         @(posedge clk21m);
         status <= {lcg_next(), lcg_next()};
         reset_rq <= 1'(lcg_next() >> 7);
         forced_scandoubler <= 1'(lcg_next() >> 9);
         @(negedge clk21m);
         e = fx_ref(status[5:3], forced_scandoubler);
         check({hq2x, scandoubler, scanlines}, e, "hq2x/scandoubler/scanlines");
         check(rewind, status[0] | status[9] | status[10] | reset_rq, "rewind");
      end
      end_test("status_decode");
   endtask

   task automatic crop_case(int w, int h);
      status_t s;
      logic [10:0] c;
      logic [23:0] a;
      logic sd;
      s = '0;
      s[2:1] = 2'(lcg_next() >> 4);
      s[5:3] = (4'(lcg_next()) < 4'd10) ? 3'd0 : 3'(lcg_next());
      s[40] = 1'(lcg_next() >> 6);
      @(posedge clk21m);
      status <= s;
      forced_scandoubler <= 1'b0;
      hdmi_width <= 12'(w);
      hdmi_height <= 12'(h);
      repeat (3) @(posedge clk21m);
      @(negedge clk21m);
      sd = s[5:3] != 0;
      c = crop_ref(w, h, sd, s[40]);
      a = aspect_ref(s[2:1], c[10]);
      check(crop_size, s[40] ? c[9:0] : 10'd0, $sformatf("crop_size %0dx%0d", w, h));
      check({arx, ary}, a, $sformatf("arx/ary %0dx%0d", w, h));
   endtask

   task automatic crop_test();
      int heights[9] = '{480, 600, 720, 768, 800, 1080, 1200, 1440, 1536};
      foreach (heights[i]) begin
         repeat (3) crop_case((heights[i] == 1536) ? 2048 : 1920, heights[i]);
      end
      repeat (12) crop_case(lcg_next() % 4096, (lcg_next() % 2048) & ~1);
      end_test("crop_aspect");
   endtask

   task automatic mount(img_size_t size);
      @(posedge clk21m);
      img_mounted <= 6'b010000;
      img_size <= size;
      @(posedge clk21m);
      img_mounted <= '0;
      @(posedge clk21m);
   endtask

   task automatic route_check(logic vsd);
      repeat (8) begin
         @(posedge clk21m);
         spi_clk <= 1'(lcg_next() >> 3);
         spi_mosi <= 1'(lcg_next() >> 5);
         card_miso <= 1'(lcg_next() >> 8);
         vsd_miso <= 1'(lcg_next() >> 11);
         @(negedge clk21m);
         check(sd_cs, vsd, "sd_cs");
         check(sd_sck, spi_clk & !vsd, "sd_sck");
         check(sd_mosi, spi_mosi & !vsd, "sd_mosi");
         check(spi_miso, vsd ? vsd_miso : card_miso, "spi_miso");
      end
   endtask

   task automatic sd_test();
      mount(32'h0010_0000);
      route_check(1'b1);
      mount(32'h0);
      route_check(1'b0);
      end_test("sd_select");
   endtask

   // Toggle MOSI once and measure how long the LEDs stay lit
   task automatic activity_run(logic vsd);
      int n;
      logic seen;
      n = 0;
      seen = 1'b0;
      @(posedge clk21m);
      card_miso <= 1'b0;
      vsd_miso <= 1'b0;
      repeat (ACT_TO + 10) @(posedge clk21m);
      @(negedge clk21m);
      check({led_user, led_disk_act}, 2'b00, "leds idle");
      @(posedge clk21m);
      spi_mosi <= ~spi_mosi;
      while (n < 100) begin
         @(posedge clk21m);
         n++;
         @(negedge clk21m);
         if (led_user || led_disk_act) begin
            if (!seen) check({led_user, led_disk_act}, {vsd, !vsd}, "led select");
            seen = 1'b1;
         end else if (seen) begin
            break;
         end
      end
      check(seen, 1'b1, "activity seen");
      check((n >= ACT_TO && n <= ACT_TO + 3), 1'b1, $sformatf("quiet cycles %0d", n));
   endtask

   task automatic activity_test();
      activity_run(1'b0);
      mount(32'h0000_0200);
      activity_run(1'b1);
      end_test("activity");
   endtask

   task automatic cassette_test();
      status_t s;
      @(posedge clk21m);
      status <= '0;
      reset_rq <= 1'b0;
      motor <= 1'b0;
      @(negedge clk21m);
      check(play, 1'b0, "play before load");
      check(rewind, 1'b0, "rewind idle");
      @(posedge clk21m);
      ioctl_index <= 16'h0105;
      ioctl_download <= 1'b1;
      repeat (3) @(posedge clk21m);
      @(negedge clk21m);
      check(rewind, 1'b1, "rewind during download");
      check(play, 1'b0, "play during download");
      @(posedge clk21m);
      ioctl_download <= 1'b0;
      repeat (2) @(posedge clk21m);
      for (int m = 0; m < 2; m++) begin
         @(posedge clk21m);
         motor <= m[0];
         @(negedge clk21m);
         check(play, !m[0], "play after load");
      end
      repeat (12) begin
         s = '0;
         s[8] = 1'(lcg_next() >> 4);
         s[9] = 1'(lcg_next() >> 6);
         s[0] = (4'(lcg_next()) == 4'd0);
         @(posedge clk21m);
         status <= s;
         cas_file_bit <= 1'(lcg_next() >> 7);
         tape_adc <= 1'(lcg_next() >> 9);
         tape_adc_act <= 1'(lcg_next() >> 12);
         @(negedge clk21m);
         check(rewind, s[9] | s[0], "rewind");
         check(cas_audio_in, s[8] ? (tape_adc & tape_adc_act) : cas_file_bit, "cas_audio_in");
      end
      end_test("cassette");
   endtask

   task automatic ddr3_test();
      repeat (40) begin
         @(posedge clk21m);
         ddr3_request_download <= 1'(lcg_next() >> 10);
         ddr3_rd_download <= 1'(lcg_next() >> 3);
         ddr3_rd_cas <= 1'(lcg_next() >> 5);
         ddr3_addr_download <= 28'(lcg_next());
         ddr3_addr_cas <= 28'(lcg_next());
         audio_in <= 16'(lcg_next());
         @(negedge clk21m);
         check({ddr3_rd, ddr3_addr}, ddr3_request_download
               ? {ddr3_rd_download, ddr3_addr_download}
               : {ddr3_rd_cas, ddr3_addr_cas}, "ddr3 port");
         check({audio_l, audio_r}, {audio_in, audio_in}, "audio_l/audio_r");
      end
      end_test("ddr3_share");
   endtask

   initial begin
      rst <= 1'b1;
      reset_rq <= 1'b0;
      status <= '0;
      forced_scandoubler <= 1'b0;
      ioctl_download <= 1'b0;
      ioctl_index <= '0;
      img_mounted <= '0;
      img_size <= '0;
      hdmi_width <= 12'd1920;
      hdmi_height <= 12'd1080;
      {spi_clk, spi_mosi, card_miso, vsd_miso} <= '0;
      {motor, cas_file_bit, tape_adc, tape_adc_act} <= '0;
      {ddr3_request_download, ddr3_rd_download, ddr3_rd_cas} <= '0;
      ddr3_addr_download <= '0;
      ddr3_addr_cas <= '0;
      audio_in <= 16'h1234;
      repeat (8) @(posedge clk21m);
      rst <= 1'b0;
      status_test();
      crop_test();
      sd_test();
      activity_test();
      cassette_test();
      ddr3_test();
      $display("Total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
